/* Bender.yml */
package:
  name: rv_frontend

sources:
  # Packages first, then the three parts and the top level
  - src/fetch_bus_pkg.sv
  - src/instr_buf_pkg.sv
  - src/fetch_addr_gen.sv
  - src/prefetch_queue.sv
  - src/instr_assembler.sv
  - src/rv_frontend.sv

  - target: test
    files:
      - bench/tb_rv_frontend.sv

/* bench/tb_rv_frontend.sv */
// Testbench for the RISC-V fetch front end with a memory model, a decode model and a reference check
`timescale 1ns/100ps

module tb_rv_frontend import fetch_bus_pkg::*, instr_buf_pkg::*;;

	localparam int PERIOD        = 40;
	localparam int RST_CYCLES    = 16;
	localparam int HOLD_CYCLES   = 30;
	localparam int N_SEQ         = 200;
	localparam int N_BUS         = 100;
	localparam int N_HOLD        = 60;
	localparam int N_JMP         = 40;
	// Generous bound on cycles per consumed instruction with random stalls on both sides
	localparam int CYC_PER_INSTR = 10;
	localparam int WATCHDOG_CYCLES = RST_CYCLES + HOLD_CYCLES + 500
		+ CYC_PER_INSTR * (N_SEQ + N_BUS + N_HOLD + 2 * N_JMP);

	logic       clk = 1'b0;
	logic       rst_n;
	addr_t      mem_addr;
	logic       mem_addr_vld;
	logic       mem_addr_rdy;
	mem_rsp_t   mem_rsp;
	addr_t      jump_target;
	logic       jump_vld;
	logic       jump_rdy;
	word_t      cir;
	logic [1:0] cir_vld;
	logic [1:0] cir_use;

	// Memory model state where beats leave in request order
	addr_t beat_q[$];
	int    due_q[$];
	int    cycle = 0;
	int    lat_next = 1;
	int    rdy_skip = 1;
	int    acc_cnt = 0;
	int    rsp_cnt = 0;
	addr_t exp_addr = RESET_VECTOR;

	// Jump channel state seen by the bus monitor
	logic  addr_held = 1'b0;
	logic  out_of_reset = 1'b0;
	logic  exp_jump_rdy;

	// Decode and compare state
	logic  decode_hold = 1'b0;
	addr_t pc = RESET_VECTOR;
	int    consumed = 0;
	word_t exp_instr;
	word_t got_instr;
	logic [1:0] exp_len;

	int    err_cnt = 0;
	int    test_err_start = 0;
	int    test_cnt = 0;
	int    fail_cnt = 0;
	int    acc_mark;

	rv_frontend i_dut (.*);

	always #(PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------
	// Memory contents and reference

	// Hash of the word address with parcel low bits forced so that about half start 32-bit code
	function automatic word_t mem_word(input addr_t a);
		word_t h;
		h = (a ^ 32'h5bd1_e995) * 32'h9e37_79b1;
		h = h ^ (h >> 13);
		h[1:0]   = h[9] ? 2'b11 : {1'b0, h[10]};
		h[17:16] = h[25] ? 2'b11 : {h[26], 1'b0};
		return h;
	endfunction

	function automatic half_t mem_half(input addr_t a);
		word_t w;
		w = mem_word({a[W_ADDR-1:2], 2'b00});
		return a[1] ? w[31:16] : w[15:0];
	endfunction

	// Expected instruction at pc where a compressed one comes back zero extended
	function automatic word_t ref_instr(input addr_t a);
		half_t lo;
		lo = mem_half(a);
		if (lo[1:0] == 2'b11)
			return {mem_half(a + 32'd2), lo};
		return {16'h0000, lo};
	endfunction

	// ------------------------------------------------------------
	// Bus and decode stimulus driven just after the clock edge

	always @(posedge clk) begin
		#2;
		cycle++;
		lat_next     = 1 + $urandom % 3;
		mem_addr_rdy = ($urandom % 4) >= rdy_skip;
		if (due_q.size() != 0 && due_q[0] <= cycle) begin
			void'(due_q.pop_front());
			mem_rsp = '{data: mem_word(beat_q.pop_front()), vld: 1'b1};
			rsp_cnt++;
		end else begin
			mem_rsp = '0;
		end
		// Decode takes a whole instruction or nothing
		if (!rst_n || decode_hold || ($urandom % 4) == 0)
			cir_use = 2'd0;
		else if (cir[1:0] == 2'b11)
			cir_use = (cir_vld == 2'd2) ? 2'd2 : 2'd0;
		else
			cir_use = (cir_vld != 2'd0) ? 2'd1 : 2'd0;
	end

	// Bus monitor where a taken jump restarts the expected address sequence
	always @(negedge clk) begin
		// Jumps are refused in reset, in the cycle after it and while an address is held
		exp_jump_rdy = rst_n && out_of_reset && !addr_held;
		assert (jump_rdy == exp_jump_rdy) else begin
			$display("ERR jump_rdy: got %h expected %h", jump_rdy, exp_jump_rdy);
			err_cnt++;
		end
		addr_held    = mem_addr_vld && !mem_addr_rdy;
		out_of_reset = rst_n;
		if (jump_vld && jump_rdy)
			exp_addr = jump_target & 32'hffff_fffc;
		if (mem_addr_vld && mem_addr_rdy) begin
			assert (mem_addr == exp_addr) else begin
				$display("ERR mem_addr: got %h expected %h", mem_addr, exp_addr);
				err_cnt++;
			end
			exp_addr = exp_addr + 32'd4;
			beat_q.push_back(mem_addr);
			due_q.push_back(cycle + lat_next);
			acc_cnt++;
		end
		assert (acc_cnt - rsp_cnt <= 2) else begin
			$display("More than two fetches outstanding at cycle %0d", cycle);
			err_cnt++;
		end
	end

	// Compare each consumed instruction with the reference
	always @(negedge clk) begin
		if (cir_use != 2'd0) begin
			exp_instr = ref_instr(pc);
			exp_len   = (exp_instr[1:0] == 2'b11) ? 2'd2 : 2'd1;
			got_instr = (cir_use == 2'd2) ? cir : {16'h0000, cir[15:0]};
			assert (cir_use == exp_len) else begin
				$display("ERR cir_use: got %h expected %h at pc %h", cir_use, exp_len, pc);
				err_cnt++;
			end
			assert (got_instr == exp_instr) else begin
				$display("ERR cir: got %h expected %h at pc %h", got_instr, exp_instr, pc);
				err_cnt++;
			end
			pc = pc + {29'd0, cir_use, 1'b0};
			consumed++;
		end
	end

	// ------------------------------------------------------------
	// Test helpers

	task automatic check_idle();
		@(negedge clk);
		assert (mem_addr_vld == 1'b0) else begin
			$display("ERR mem_addr_vld: got %h expected 0", mem_addr_vld);
			err_cnt++;
		end
		assert (cir_vld == 2'd0) else begin
			$display("ERR cir_vld: got %h expected 0", cir_vld);
			err_cnt++;
		end
	endtask

	task automatic run_instrs(input int n);
		int target;
		target = consumed + n;
		while (consumed < target)
			@(posedge clk);
	endtask

	// The new pc takes effect on the edge that completes the handshake
	task automatic take_jump(input addr_t target);
		@(posedge clk);
		#2;
		jump_target = target;
		jump_vld    = 1'b1;
		do
			@(negedge clk);
		while (!jump_rdy);
		@(posedge clk);
		pc = target;
		#2;
		jump_vld = 1'b0;
	endtask

	task automatic end_test(input string name);
		if (err_cnt == test_err_start) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s FAILED with %0d errors", name, err_cnt - test_err_start);
			fail_cnt++;
		end
		test_cnt++;
		test_err_start = err_cnt;
	endtask

	// ------------------------------------------------------------
	// Test sequence

	initial begin
		void'($urandom(60544));
		rst_n        = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_rsp      = '0;
		jump_target  = '0;
		jump_vld     = 1'b0;
		cir_use      = 2'd0;
		repeat (RST_CYCLES)
			check_idle();
		@(posedge clk);
		#2;
		rst_n = 1'b1;
		check_idle();
		end_test("reset");

		run_instrs(N_SEQ);
		end_test("sequential stream");

		// Slower bus so that addresses get held more often
		rdy_skip = 2;
		run_instrs(N_BUS);
		rdy_skip = 1;
		end_test("bus ordering");

		// Fetch must come to rest once everything behind cir has filled
		decode_hold = 1'b1;
		repeat (HOLD_CYCLES - 8)
			@(posedge clk);
		acc_mark = acc_cnt;
		repeat (8)
			@(posedge clk);
		assert (acc_cnt == acc_mark) else begin
			$display("Fetch requests kept going while decode was stalled");
			err_cnt++;
		end
		decode_hold = 1'b0;
		run_instrs(N_HOLD);
		end_test("decode back-pressure");

		while (acc_cnt == rsp_cnt)
			@(negedge clk);
		take_jump(32'h0000_2340);
		run_instrs(N_JMP);
		end_test("word jump");

		take_jump(32'h0000_3a62);
		run_instrs(N_JMP);
		end_test("halfword jump");

		$display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Timeout after %0d cycles, the instruction stream stopped", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* project.f */
src/fetch_bus_pkg.sv
src/instr_buf_pkg.sv
src/fetch_addr_gen.sv
src/prefetch_queue.sv
src/instr_assembler.sv
src/rv_frontend.sv
bench/tb_rv_frontend.sv

/* src/fetch_addr_gen.sv */
// Fetch address generator that issues word fetches, takes jumps and discards stale beats
`timescale 1ns/100ps

module fetch_addr_gen import fetch_bus_pkg::*, instr_buf_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	output addr_t        mem_addr,
	output logic         mem_addr_vld,
	input  logic         mem_addr_rdy,
	input  mem_rsp_t     mem_rsp,
	input  addr_t        jump_target,
	input  logic         jump_vld,
	output logic         jump_rdy,
	input  logic         q_full,
	input  logic         q_almost_full,
	output logic         flush,
	output fetch_entry_t fetch_in,
	output logic         fetch_in_vld
);

	// Fetch address runs ahead of decode in whole words
	addr_t      fetch_addr;
	logic       reset_holdoff;
	logic       addr_hold;
	logic [1:0] pending;
	logic [1:0] flush_pending;
	// Set by a jump to an odd halfword until its first beat arrives
	logic       upper_only;

	logic       req_vld;
	logic       accepted;
	logic       jump_now;
	logic       fetch_stall;

	// ------------------------------------------------------------
	// Request generation

	// A held address must not move, so a jump waits until the bus takes it
	assign jump_rdy = !addr_hold && !reset_holdoff;
	assign jump_now = jump_vld && jump_rdy;

	// Pending counts are registered so that ready never reaches the request combinationally
	assign fetch_stall = q_full || (q_almost_full && |pending) || pending > 2'd1;

	always_comb begin
		mem_addr = fetch_addr;
		req_vld  = 1'b0;
		if (addr_hold) begin
			req_vld = 1'b1;
		end else if (jump_vld) begin
			mem_addr = {jump_target[W_ADDR-1:2], 2'b00};
			// With two beats in flight the target is parked in fetch_addr instead
			req_vld  = !pending[1];
		end else if (!fetch_stall) begin
			req_vld = 1'b1;
		end
	end

	assign mem_addr_vld = req_vld && !reset_holdoff;
	assign accepted     = mem_addr_vld && mem_addr_rdy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr    <= RESET_VECTOR;
			reset_holdoff <= 1'b1;
			addr_hold     <= 1'b0;
		end else begin
			reset_holdoff <= 1'b0;
			addr_hold     <= mem_addr_vld && !mem_addr_rdy;
			if (jump_now) begin
				// Skip past the target word when it went out on the bus this cycle
				fetch_addr <= {jump_target[W_ADDR-1:2] + (W_ADDR-2)'(accepted), 2'b00};
			end else if (accepted) begin
				fetch_addr <= fetch_addr + 32'd4;
			end
		end
	end

	// ------------------------------------------------------------
	// Outstanding beat tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending       <= 2'd0;
			flush_pending <= 2'd0;
			upper_only    <= 1'b0;
		end else begin
			pending <= pending + {1'b0, accepted} - {1'b0, mem_rsp.vld};
			// Every beat already on its way belongs to the old stream
			if (jump_now) begin
				flush_pending <= pending - {1'b0, mem_rsp.vld};
			end else if (|flush_pending && mem_rsp.vld) begin
				flush_pending <= flush_pending - 2'd1;
			end
			if (jump_now) begin
				upper_only <= jump_target[1];
			end else if (fetch_in_vld) begin
				upper_only <= 1'b0;
			end
		end
	end

	assign flush        = jump_now;
	assign fetch_in_vld = mem_rsp.vld && flush_pending == 2'd0;
	// The lower halfword of an odd jump target lies before the target itself
	assign fetch_in     = '{data: mem_rsp.data, hw_vld: hw_vld_t'({1'b1, !upper_only})};

endmodule

/* src/fetch_bus_pkg.sv */
// Fetch bus package with the address, data word and memory response types of the front end

package fetch_bus_pkg;

	// ------------------------------------------------------------
	// Bus widths

	// Byte address width of the instruction bus
	localparam int W_ADDR = 32;

	// A byte address on the instruction bus
	typedef logic [W_ADDR-1:0] addr_t;

	// One bus data word, always fetched whole and word aligned
	typedef logic [31:0] word_t;

	// ------------------------------------------------------------
	// Response channel

	// One returned bus beat
	// The channel has no back-pressure, so the beat is only a data word and its strobe
	typedef struct packed {
		word_t data;
		logic  vld;
	} mem_rsp_t;

	// ------------------------------------------------------------
	// Boot

	// First fetch address after reset
	localparam addr_t RESET_VECTOR = 32'h0000_0100;

endpackage

/* src/instr_assembler.sv */
// Instruction assembler that realigns fetched halfwords into cir for decode
`timescale 1ns/100ps

module instr_assembler import fetch_bus_pkg::*, instr_buf_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         flush,
	input  fetch_entry_t head,
	input  logic         head_vld,
	output logic         take,
	output word_t        cir,
	output logic [1:0]   cir_vld,
	input  logic [1:0]   cir_use
);

	// Level counts valid halfwords in {spare, cir}, from 0 to 3
	logic [1:0]          level;
	half_t               spare;

	logic [2*W_HALF-1:0] fresh_aligned;
	logic [3*W_HALF-1:0] shifted;
	logic [3*W_HALF-1:0] merged;
	logic [1:0]          level_left;
	logic [1:0]          fill;
	logic [1:0]          level_next;

	// ------------------------------------------------------------
	// Realignment

	// An upper-half-only word has its valid parcel moved to the bottom
	assign fresh_aligned = {
		head.data[W_HALF +: W_HALF],
		head.hw_vld[0] ? head.data[0 +: W_HALF] : head.data[W_HALF +: W_HALF]
	};

	// Remaining halfwords slide down over what decode consumed
	// Slots above the new level hold don't-care values chosen to save muxes
	always_comb begin
		case (cir_use)
			2'd2:    shifted = {spare, cir[W_HALF +: W_HALF], spare};
			2'd1:    shifted = {spare, spare, cir[W_HALF +: W_HALF]};
			default: shifted = {spare, cir};
		endcase
	end

	assign level_left = level - cir_use;

	// A half word fits with two halfwords left, a full word needs one or less
	assign take = level_left <= (&head.hw_vld ? 2'd1 : 2'd2);

	// Fresh data lands just above what is left
	always_comb begin
		if (!take)
			merged = shifted;
		else if (level_left[1])
			merged = {fresh_aligned[0 +: W_HALF], shifted[0 +: 2*W_HALF]};
		else if (level_left[0])
			merged = {fresh_aligned, shifted[0 +: W_HALF]};
		else
			merged = {shifted[2*W_HALF +: W_HALF], fresh_aligned};
	end

	// ------------------------------------------------------------
	// Level tracking

	always_comb begin
		fill = 2'd0;
		if (take && head_vld)
			fill = &head.hw_vld ? 2'd2 : 2'd1;
		level_next = flush ? 2'd0 : level_left + fill;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level   <= 2'd0;
			cir_vld <= 2'd0;
		end else begin
			level   <= level_next;
			// Decode only sees cir, so the spare halfword does not count
			cir_vld <= level_next[1] ? 2'd2 : level_next;
		end
	end

	always_ff @(posedge clk) begin
		{spare, cir} <= merged;
	end

endmodule

/* src/instr_buf_pkg.sv */
// Instruction buffer package with the halfword, halfword-validity and queue-entry types

package instr_buf_pkg;

	// ------------------------------------------------------------
	// Parcels

	// Width of one instruction parcel
	localparam int W_HALF = 16;

	// One 16-bit instruction parcel, a whole compressed instruction or half of a 32-bit one
	typedef logic [W_HALF-1:0] half_t;

	// Halfword validity of a fetched word
	// Bit 0 is the lower halfword and bit 1 the upper halfword
	typedef logic [1:0] hw_vld_t;

	// ------------------------------------------------------------
	// Queue

	// A fetched word together with the halfwords of it that are worth decoding
	typedef struct packed {
		fetch_bus_pkg::word_t data;
		hw_vld_t              hw_vld;
	} fetch_entry_t;

	// Two entries are enough to keep fetching at full rate while decode stalls
	localparam int QUEUE_DEPTH = 2;

endpackage

/* src/prefetch_queue.sv */
// Prefetch queue holding fetched words with their halfword validity, bypassed when empty
`timescale 1ns/100ps

module prefetch_queue import fetch_bus_pkg::*, instr_buf_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         flush,
	input  fetch_entry_t fetch_in,
	input  logic         fetch_in_vld,
	input  logic         take,
	output fetch_entry_t head,
	output logic         head_vld,
	output logic         q_full,
	output logic         q_almost_full
);

	word_t   q_data [QUEUE_DEPTH];
	hw_vld_t q_hw   [QUEUE_DEPTH];
	logic    q_vld  [QUEUE_DEPTH];

	// Neighbours of each entry, the one above feeds it on a shift
	word_t   up_data [QUEUE_DEPTH];
	hw_vld_t up_hw   [QUEUE_DEPTH];
	logic    up_vld  [QUEUE_DEPTH];
	logic    dn_vld  [QUEUE_DEPTH];

	logic    q_empty;
	logic    push;
	logic    pop;

	always_comb begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			q_vld[i] = |q_hw[i];
		end
		// Above the top entry there is only the incoming word, never valid
		for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
			up_data[i] = q_data[i+1];
			up_hw[i]   = q_hw[i+1];
			up_vld[i]  = q_vld[i+1];
		end
		up_data[QUEUE_DEPTH-1] = fetch_in.data;
		up_hw[QUEUE_DEPTH-1]   = '0;
		up_vld[QUEUE_DEPTH-1]  = 1'b0;
		dn_vld[0] = 1'b1;
		for (int i = 1; i < QUEUE_DEPTH; i++) begin
			dn_vld[i] = q_vld[i-1];
		end
	end

	// Entries are compact toward entry 0, so only the last one shows fullness
	assign q_empty       = !q_vld[0];
	assign q_full        = q_vld[QUEUE_DEPTH-1];
	assign q_almost_full = q_vld[QUEUE_DEPTH-2];

	// When empty and the assembler has room, the word skips the queue
	assign push     = fetch_in_vld && !(take && q_empty);
	assign pop      = take && !q_empty;
	assign head     = q_empty ? fetch_in : '{data: q_data[0], hw_vld: q_hw[0]};
	assign head_vld = !q_empty || fetch_in_vld;

	always_ff @(posedge clk) begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (pop || (push && !q_vld[i])) begin
				q_data[i] <= up_vld[i] ? up_data[i] : fetch_in.data;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				q_hw[i] <= '0;
			end
		end else begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				if (flush)
					q_hw[i] <= '0;
				else if (up_vld[i] && pop)
					q_hw[i] <= up_hw[i];
				else if (q_vld[i] && pop)
					q_hw[i] <= push ? fetch_in.hw_vld : hw_vld_t'(2'b00);
				else if (q_vld[i])
					q_hw[i] <= q_hw[i];
				else if (push && !pop && dn_vld[i])
					q_hw[i] <= fetch_in.hw_vld;
				else
					q_hw[i] <= '0;
			end
		end
	end

endmodule

/* src/rv_frontend.sv */
// RISC-V fetch front end joining address generation, prefetch queue and instruction assembly
`timescale 1ns/100ps

module rv_frontend import fetch_bus_pkg::*, instr_buf_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// Memory address and response channels
	output addr_t      mem_addr,
	output logic       mem_addr_vld,
	input  logic       mem_addr_rdy,
	input  mem_rsp_t   mem_rsp,
	// Jump channel
	input  addr_t      jump_target,
	input  logic       jump_vld,
	output logic       jump_rdy,
	// Decode channel
	output word_t      cir,
	output logic [1:0] cir_vld,
	input  logic [1:0] cir_use
);

	fetch_entry_t fetch_in;
	logic         fetch_in_vld;
	logic         flush;
	fetch_entry_t head;
	logic         head_vld;
	logic         take;
	logic         q_full;
	logic         q_almost_full;

	// ------------------------------------------------------------
	// Fetch, queue, assemble

	fetch_addr_gen i_addr_gen (
		.clk, .rst_n, .mem_addr, .mem_addr_vld, .mem_addr_rdy, .mem_rsp,
		.jump_target, .jump_vld, .jump_rdy, .q_full, .q_almost_full,
		.flush, .fetch_in, .fetch_in_vld
	);

	prefetch_queue i_queue (
		.clk, .rst_n, .flush, .fetch_in, .fetch_in_vld, .take,
		.head, .head_vld, .q_full, .q_almost_full
	);

	instr_assembler i_asm (
		.clk, .rst_n, .flush, .head, .head_vld, .take, .cir, .cir_vld, .cir_use
	);

endmodule
